/* digit_pair_encoder.sv */
/*
 * Two-digit value to tens and ones glyph codes, fixed 3-cycle latency.
 * BINARY_INPUT = 0 takes packed BCD, 1 takes binary 0..99.
 * Binary values above 99 give meaningless tens glyphs.
 */
module digit_pair_encoder #(
    parameter bit BINARY_INPUT = 1'b0
) (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic [7:0]           value,
    output lcd_text_pkg::glyph_t tens_glyph,
    output lcd_text_pkg::glyph_t ones_glyph
);

    import lcd_text_pkg::*;

    localparam glyph_t ZERO_GLYPH = glyph_t'(ASCII_ZERO - ASCII_OFFSET);

    logic [7:0] value_q;
    logic [3:0] tens_d;
    logic [3:0] ones_d;
    logic [3:0] tens_q;
    logic [3:0] ones_q;

    // stage 1, capture
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            value_q <= '0;
        end else begin
            value_q <= value;
        end
    end

    // digit split
    if (BINARY_INPUT) begin : g_binary
        logic [7:0] quot;
        logic [7:0] rem;
        assign quot   = value_q / 8'd10;
        assign rem    = value_q % 8'd10;
        assign tens_d = quot[3:0];  // fits for 0..99
        assign ones_d = rem[3:0];
    end else begin : g_bcd
        assign tens_d = value_q[7:4];
        assign ones_d = value_q[3:0];
    end

    // stage 2, decimal digits
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tens_q <= 4'd0;
            ones_q <= 4'd0;
        end else begin
            tens_q <= tens_d;
            ones_q <= ones_d;
        end
    end

    // stage 3, glyph codes
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tens_glyph <= ZERO_GLYPH;
            ones_glyph <= ZERO_GLYPH;
        end else begin
            tens_glyph <= digit_glyph(tens_q);
            ones_glyph <= digit_glyph(ones_q);
        end
    end

endmodule

/* flist.f */
+incdir+.
lcd_text_pkg.sv
lcd_start_pulse.sv
digit_pair_encoder.sv
screen_layout.sv
lcd_text_ctrl.sv
tb_lcd_text_ctrl.sv

/* lcd_start_pulse.sv */
/*
 * Single start strobe per rise of init_done.
 * START_DELAY must be 1 or more.
 * init_done has to go low before another strobe can fire.
 */
module lcd_start_pulse #(
    parameter int START_DELAY = lcd_text_pkg::START_DELAY_DEF
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic init_done,
    output logic char_start
);

    localparam int               CNT_W    = $clog2(START_DELAY + 1);
    localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(START_DELAY);
    localparam logic [CNT_W-1:0] CNT_FIRE = CNT_W'(START_DELAY - 1);

    logic [CNT_W-1:0] delay_cnt;

    // delay counter, sticks at START_DELAY until init_done drops
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            delay_cnt <= '0;
        end else if (!init_done) begin
            delay_cnt <= '0;  // re-arm while panel not ready
        end else if (delay_cnt != CNT_MAX) begin
            delay_cnt <= delay_cnt + 1'b1;
        end
    end

    // strobe on the edge where the counter reaches its limit
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            char_start <= 1'b0;
        end else begin
            char_start <= init_done && (delay_cnt == CNT_FIRE);
        end
    end

endmodule

/* lcd_text_ctrl.sv */
/*
 * Text-screen controller for the status LCD.
 * hour, minute and second are BCD; temperature and humidity are binary 0..99.
 * Field inputs need 3 cycles to reach the layout after a change.
 */
module lcd_text_ctrl #(
    parameter int START_DELAY = lcd_text_pkg::START_DELAY_DEF
) (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 init_done,
    input  logic                 char_done,
    input  logic [7:0]           hour,
    input  logic [7:0]           minute,
    input  logic [7:0]           second,
    input  logic [7:0]           temperature,
    input  logic [7:0]           humidity,
    output logic                 char_start,
    output lcd_text_pkg::glyph_t glyph,
    output lcd_text_pkg::coord_t start_x,
    output lcd_text_pkg::coord_t start_y
);

    import lcd_text_pkg::*;

    glyph_t hour_tens;
    glyph_t hour_ones;
    glyph_t minute_tens;
    glyph_t minute_ones;
    glyph_t second_tens;
    glyph_t second_ones;
    glyph_t temp_tens;
    glyph_t temp_ones;
    glyph_t humi_tens;
    glyph_t humi_ones;

    // ------------------------------
    // start strobe
    // ------------------------------
    lcd_start_pulse #(
        .START_DELAY (START_DELAY)
    ) lcd_start_pulse_inst (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .init_done  (init_done),
        .char_start (char_start)
    );

    // ------------------------------
    // digit encoders
    // ------------------------------
    // clock fields, BCD
    digit_pair_encoder #(.BINARY_INPUT(1'b0)) hour_enc_inst (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .value      (hour),
        .tens_glyph (hour_tens),
        .ones_glyph (hour_ones)
    );

    digit_pair_encoder #(.BINARY_INPUT(1'b0)) minute_enc_inst (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .value      (minute),
        .tens_glyph (minute_tens),
        .ones_glyph (minute_ones)
    );

    digit_pair_encoder #(.BINARY_INPUT(1'b0)) second_enc_inst (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .value      (second),
        .tens_glyph (second_tens),
        .ones_glyph (second_ones)
    );

    // sensor fields, binary
    digit_pair_encoder #(.BINARY_INPUT(1'b1)) temp_enc_inst (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .value      (temperature),
        .tens_glyph (temp_tens),
        .ones_glyph (temp_ones)
    );

    digit_pair_encoder #(.BINARY_INPUT(1'b1)) humi_enc_inst (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .value      (humidity),
        .tens_glyph (humi_tens),
        .ones_glyph (humi_ones)
    );

    // ------------------------------
    // layout
    // ------------------------------
    screen_layout screen_layout_inst (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .init_done   (init_done),
        .char_done   (char_done),
        .hour_tens   (hour_tens),
        .hour_ones   (hour_ones),
        .minute_tens (minute_tens),
        .minute_ones (minute_ones),
        .second_tens (second_tens),
        .second_ones (second_ones),
        .temp_tens   (temp_tens),
        .temp_ones   (temp_ones),
        .humi_tens   (humi_tens),
        .humi_ones   (humi_ones),
        .glyph       (glyph),
        .start_x     (start_x),
        .start_y     (start_y)
    );

endmodule

/* lcd_text_pkg.sv */
/*
 * Types and constants shared by the LCD text-screen controller.
 * Glyph codes index a font ROM that starts at ASCII space (32).
 * Only printable 7-bit ASCII maps to a valid glyph.
 */
package lcd_text_pkg;

    // ------------------------------
    // types
    // ------------------------------
    typedef logic [6:0] glyph_t;     // font ROM index, ascii - 32
    typedef logic [8:0] coord_t;     // pixel coordinate on the panel
    typedef logic [7:0] cell_idx_t;  // position in the cell list

    // ------------------------------
    // geometry and codes
    // ------------------------------
    // 8x16 font cell
    localparam int GLYPH_W = 8;
    localparam int GLYPH_H = 16;

    localparam int ASCII_OFFSET = 32;  // font ROM starts at space
    localparam int ASCII_ZERO   = 48;

    localparam int LAYOUT_LEN      = 35;  // cells 0..34
    localparam int START_DELAY_DEF = 3;   // cycles from init_done to strobe

    // ------------------------------
    // helpers
    // ------------------------------
    // ascii code to font index
    function automatic glyph_t ascii_to_glyph(input logic [7:0] ascii);
        return glyph_t'(ascii - 8'(ASCII_OFFSET));
    endfunction

    // decimal digit 0..9 to font index
    function automatic glyph_t digit_glyph(input logic [3:0] digit);
        return ascii_to_glyph(8'(ASCII_ZERO) + {4'd0, digit});
    endfunction

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LCD text controller testbench with Verilator.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot change to the project directory"
    exit 1
fi

verilator --binary --timing -f flist.f --top-module tb_lcd_text_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_lcd_text_ctrl)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

/* screen_layout.sv */
/*
 * Walks the fixed 35-cell screen, one cell per char_done.
 * Live digits are taken as they stand when their cell is registered.
 * Indices past the layout give glyph 0 at the origin; the index wraps at 256.
 */
module screen_layout (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 init_done,
    input  logic                 char_done,
    input  lcd_text_pkg::glyph_t hour_tens,
    input  lcd_text_pkg::glyph_t hour_ones,
    input  lcd_text_pkg::glyph_t minute_tens,
    input  lcd_text_pkg::glyph_t minute_ones,
    input  lcd_text_pkg::glyph_t second_tens,
    input  lcd_text_pkg::glyph_t second_ones,
    input  lcd_text_pkg::glyph_t temp_tens,
    input  lcd_text_pkg::glyph_t temp_ones,
    input  lcd_text_pkg::glyph_t humi_tens,
    input  lcd_text_pkg::glyph_t humi_ones,
    output lcd_text_pkg::glyph_t glyph,
    output lcd_text_pkg::coord_t start_x,
    output lcd_text_pkg::coord_t start_y
);

    import lcd_text_pkg::*;

    cell_idx_t  cell_idx;
    glyph_t     cell_glyph;
    logic [2:0] cell_row;    // text row, 0..5
    logic [3:0] cell_col;    // text column, 0..15
    coord_t     cell_x;
    coord_t     cell_y;

    // ------------------------------
    // cell index
    // ------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cell_idx <= '0;
        end else if (init_done && char_done) begin
            cell_idx <= cell_idx + 1'b1;  // next cell once the drawer is done
        end
    end

    // ------------------------------
    // glyph table
    // ------------------------------
    always_comb begin
        case (cell_idx) inside
            8'd0:           cell_glyph = ascii_to_glyph("x");
            8'd1:           cell_glyph = ascii_to_glyph("y");
            8'd2:           cell_glyph = ascii_to_glyph("z");
            [8'd3:8'd18]:   cell_glyph = ascii_to_glyph("-");  // full-width rule
            8'd19, 8'd28:   cell_glyph = ascii_to_glyph(" ");
            // clock line HH:MM:SS
            8'd20:          cell_glyph = hour_tens;
            8'd21:          cell_glyph = hour_ones;
            8'd22, 8'd25:   cell_glyph = ascii_to_glyph(":");
            8'd23:          cell_glyph = minute_tens;
            8'd24:          cell_glyph = minute_ones;
            8'd26:          cell_glyph = second_tens;
            8'd27:          cell_glyph = second_ones;
            // sensor line TTCHH%
            8'd29:          cell_glyph = temp_tens;
            8'd30:          cell_glyph = temp_ones;
            8'd31:          cell_glyph = ascii_to_glyph("C");  // stands in for degree sign
            8'd32:          cell_glyph = humi_tens;
            8'd33:          cell_glyph = humi_ones;
            8'd34:          cell_glyph = ascii_to_glyph("%");
            default:        cell_glyph = '0;
        endcase
    end

    // ------------------------------
    // row and column table
    // ------------------------------
    always_comb begin
        case (cell_idx) inside
            [8'd0:8'd2]: begin
                cell_row = 3'd0;
                cell_col = 4'(cell_idx + 8'd7);  // header centred, cols 7..9
            end
            [8'd3:8'd18]: begin
                cell_row = 3'd1;
                cell_col = 4'(cell_idx - 8'd3);
            end
            8'd19: begin
                cell_row = 3'd2;
                cell_col = 4'd4;
            end
            [8'd20:8'd27]: begin
                cell_row = 3'd3;
                cell_col = 4'(cell_idx - 8'd16);  // cols 4..11
            end
            8'd28: begin
                cell_row = 3'd4;
                cell_col = 4'd4;
            end
            [8'd29:8'd34]: begin
                cell_row = 3'd5;
                cell_col = 4'(cell_idx - 8'd24);  // cols 5..10
            end
            default: begin
                cell_row = 3'd0;
                cell_col = 4'd0;
            end
        endcase
    end

    // pixel position of the top-left corner
    assign cell_x = coord_t'(cell_col) * coord_t'(GLYPH_W);
    assign cell_y = coord_t'(cell_row) * coord_t'(GLYPH_H);

    // ------------------------------
    // output registers
    // ------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            glyph   <= '0;
            start_x <= '0;
            start_y <= '0;
        end else if (!init_done) begin
            // panel not ready
            glyph   <= '0;
            start_x <= '0;
            start_y <= '0;
        end else begin
            glyph   <= cell_glyph;
            start_x <= cell_x;
            start_y <= cell_y;
        end
    end

endmodule

/* tb_layout_table.svh */
/*
 * Cell walk table for the LCD text controller testbench.
 * Rows run in order and the cell index carries over from row to row.
 * Strobe counts assume the walk starts at cell 0 with init_done high.
 */
`ifndef TB_LAYOUT_TABLE_SVH
`define TB_LAYOUT_TABLE_SVH

// where the expected glyph comes from
localparam logic [2:0] SRC_FIXED  = 3'd0;  // ascii char in ch
localparam logic [2:0] SRC_TEMP_T = 3'd1;
localparam logic [2:0] SRC_TEMP_O = 3'd2;
localparam logic [2:0] SRC_HUMI_T = 3'd3;
localparam logic [2:0] SRC_HUMI_O = 3'd4;
localparam logic [2:0] SRC_NONE   = 3'd5;  // blanked output, glyph 0

typedef struct packed {
    int         strobes;  // char_done pulses before the check
    logic [7:0] hour;     // BCD
    logic [7:0] minute;
    logic [7:0] second;
    logic [2:0] src;
    logic [7:0] ch;
    int         row;      // text row and column of the expected cell
    int         col;
    logic       drop;     // init_done low for this row
} layout_row_t;

layout_row_t row_tbl[$];
string       row_names[$];

task automatic add_row(input string name, input int strobes, input logic [7:0] hh,
                       input logic [7:0] mm, input logic [7:0] ss, input logic [2:0] src,
                       input logic [7:0] ch, input int row, input int col, input logic drop);
    layout_row_t r;
    r.strobes = strobes;
    r.hour    = hh;
    r.minute  = mm;
    r.second  = ss;
    r.src     = src;
    r.ch      = ch;
    r.row     = row;
    r.col     = col;
    r.drop    = drop;
    row_tbl.push_back(r);
    row_names.push_back(name);
endtask

task automatic build_table();
    //       name                strb  hour   minute second source      char   r  c   drop
    add_row("hdr_x",             0,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "x",   0, 7,  1'b0);
    add_row("hdr_z",             2,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "z",   0, 9,  1'b0);
    add_row("rule_first",        1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "-",   1, 0,  1'b0);
    add_row("rule_last",         15, 8'h23, 8'h59, 8'h07, SRC_FIXED,  "-",   1, 15, 1'b0);
    add_row("blank_row2",        1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  " ",   2, 4,  1'b0);
    add_row("hour_tens",         1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "2",   3, 4,  1'b0);
    add_row("hour_tens_zero",    0,  8'h00, 8'h00, 8'h00, SRC_FIXED,  "0",   3, 4,  1'b0);
    add_row("hour_ones",         1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "3",   3, 5,  1'b0);
    add_row("colon_hm",          1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  ":",   3, 6,  1'b0);
    add_row("minute_tens",       1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "5",   3, 7,  1'b0);
    add_row("minute_ones",       1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "9",   3, 8,  1'b0);
    add_row("minute_ones_zero",  0,  8'h00, 8'h00, 8'h00, SRC_FIXED,  "0",   3, 8,  1'b0);
    add_row("colon_ms",          1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  ":",   3, 9,  1'b0);
    add_row("second_tens",       1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "0",   3, 10, 1'b0);
    add_row("second_ones",       1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "7",   3, 11, 1'b0);
    add_row("second_ones_zero",  0,  8'h00, 8'h00, 8'h00, SRC_FIXED,  "0",   3, 11, 1'b0);
    add_row("blank_row4",        1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  " ",   4, 4,  1'b0);
    add_row("temp_tens",         1,  8'h23, 8'h59, 8'h07, SRC_TEMP_T, 8'h00, 5, 5,  1'b0);
    add_row("temp_ones",         1,  8'h23, 8'h59, 8'h07, SRC_TEMP_O, 8'h00, 5, 6,  1'b0);
    add_row("temp_unit",         1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "C",   5, 7,  1'b0);
    add_row("humi_tens",         1,  8'h23, 8'h59, 8'h07, SRC_HUMI_T, 8'h00, 5, 8,  1'b0);
    add_row("humi_ones",         1,  8'h23, 8'h59, 8'h07, SRC_HUMI_O, 8'h00, 5, 9,  1'b0);
    add_row("humi_unit",         1,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "%",   5, 10, 1'b0);
    add_row("init_drop",         0,  8'h23, 8'h59, 8'h07, SRC_NONE,   8'h00, 0, 0,  1'b1);
    add_row("init_back",         0,  8'h23, 8'h59, 8'h07, SRC_FIXED,  "%",   5, 10, 1'b0);
    add_row("past_end",          1,  8'h23, 8'h59, 8'h07, SRC_NONE,   8'h00, 0, 0,  1'b0);
    add_row("past_end_far",      10, 8'h23, 8'h59, 8'h07, SRC_NONE,   8'h00, 0, 0,  1'b0);
endtask

`endif

/* tb_lcd_text_ctrl.sv */
/*
 * Testbench for the LCD text controller, default START_DELAY.
 * Outputs are sampled on the falling edge, inputs change on the rising edge.
 * Sensor values are random, 0..99, from a fixed seed.
 */
module tb_lcd_text_ctrl;

    import lcd_text_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int START_DELAY = START_DELAY_DEF;

    logic                 sys_clk;
    logic                 sys_rst_n;
    logic                 init_done;
    logic                 char_done;
    logic [7:0]           hour;
    logic [7:0]           minute;
    logic [7:0]           second;
    logic [7:0]           temperature;
    logic [7:0]           humidity;
    logic                 char_start;
    glyph_t               glyph;
    coord_t               start_x;
    coord_t               start_y;

    int seed = 71446;
    int temp_val;
    int humi_val;
    int err_cnt  = 0;
    int test_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    `include "tb_layout_table.svh"

    lcd_text_ctrl lcd_text_ctrl_inst (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .init_done   (init_done),
        .char_done   (char_done),
        .hour        (hour),
        .minute      (minute),
        .second      (second),
        .temperature (temperature),
        .humidity    (humidity),
        .char_start  (char_start),
        .glyph       (glyph),
        .start_x     (start_x),
        .start_y     (start_y)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // ------------------------------
    // checking and reporting
    // ------------------------------
    task automatic check_value(input string test_name, input string field,
                               input int expected, input int actual);
        if (expected != actual) begin
            err_cnt++;
            $display("MISMATCH %s %s: expected %0d, actual %0d",
                     test_name, field, expected, actual);
        end
    endtask

    task automatic report_test(input string test_name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("[pass] %s", test_name);
        end else begin
            fail_cnt++;
            $display("[fail] %s", test_name);
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic idle_outputs_test();
        int errs_before;
        errs_before = err_cnt;
        repeat (2) @(posedge sys_clk);
        @(negedge sys_clk);
        check_value("idle_outputs", "char_start", 0, int'(char_start));
        check_value("idle_outputs", "glyph", 0, int'(glyph));
        check_value("idle_outputs", "start_x", 0, int'(start_x));
        check_value("idle_outputs", "start_y", 0, int'(start_y));
        report_test("idle_outputs", errs_before);
    endtask

    // strobe seen at the START_DELAY-th edge after the first edge with init_done high
    task automatic start_strobe_test();
        int errs_before;
        int p;
        errs_before = err_cnt;
        @(posedge sys_clk);
        init_done <= 1'b1;
        for (p = 1; p <= START_DELAY + 20; p++) begin
            @(posedge sys_clk);
            @(negedge sys_clk);
            check_value("start_strobe", "char_start", (p == START_DELAY) ? 1 : 0,
                        int'(char_start));
        end
        report_test("start_strobe", errs_before);
    endtask

    task automatic layout_row_test(input int idx);
        layout_row_t r;
        string       name;
        int          errs_before;
        int          exp_glyph;
        r           = row_tbl[idx];
        name        = row_names[idx];
        errs_before = err_cnt;
        temp_val    = $unsigned($random(seed)) % 100;
        humi_val    = $unsigned($random(seed)) % 100;
        @(posedge sys_clk);
        hour        <= r.hour;
        minute      <= r.minute;
        second      <= r.second;
        temperature <= 8'(temp_val);
        humidity    <= 8'(humi_val);
        init_done   <= ~r.drop;
        repeat (4) @(posedge sys_clk);  // encoders settle before any strobe
        if (r.strobes > 0) begin
            char_done <= 1'b1;
            repeat (r.strobes) @(posedge sys_clk);
            char_done <= 1'b0;
        end
        @(posedge sys_clk);  // output register catches the new cell
        @(negedge sys_clk);
        case (r.src)
            SRC_TEMP_T: exp_glyph = temp_val / 10 + ASCII_ZERO - ASCII_OFFSET;
            SRC_TEMP_O: exp_glyph = temp_val % 10 + ASCII_ZERO - ASCII_OFFSET;
            SRC_HUMI_T: exp_glyph = humi_val / 10 + ASCII_ZERO - ASCII_OFFSET;
            SRC_HUMI_O: exp_glyph = humi_val % 10 + ASCII_ZERO - ASCII_OFFSET;
            SRC_NONE:   exp_glyph = 0;
            default:    exp_glyph = int'(r.ch) - ASCII_OFFSET;
        endcase
        check_value(name, "glyph", exp_glyph, int'(glyph));
        check_value(name, "start_x", r.col * GLYPH_W, int'(start_x));
        check_value(name, "start_y", r.row * GLYPH_H, int'(start_y));
        report_test(name, errs_before);
    endtask

    // ------------------------------
    // main sequence and watchdog
    // ------------------------------
    initial begin
        int idx;
        sys_rst_n   = 1'b0;
        init_done   = 1'b0;
        char_done   = 1'b0;
        hour        = 8'h00;
        minute      = 8'h00;
        second      = 8'h00;
        temperature = 8'd0;
        humidity    = 8'd0;
        build_table();
        repeat (5) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        idle_outputs_test();
        start_strobe_test();
        for (idx = 0; idx < row_tbl.size(); idx++) begin
            layout_row_test(idx);
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
                 test_cnt, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        int limit_cycles;
        #1;  // table is built at time 0
        limit_cycles = row_tbl.size() * 10 + 100;
        #(limit_cycles * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d clock cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule
